//--- src/intra_nbr_pkg.sv
// Intra luma neighbour storage shared definitions
// Pixel widths, counter codes, mode enums and control structs
package intra_nbr_pkg;

	//----------------------------------------
	// Sizes
	//----------------------------------------
	localparam int PIX_W  = 8;
	localparam int LANES  = 4;
	localparam int GROUPS = 4;
	localparam int BLK_W  = 4;
	localparam int GRP_W  = 2;
	localparam int CNT_W  = 3;

	// Counter codes from the block sequencer
	localparam logic [CNT_W-1:0] SUM_READY    = 3'd3;
	localparam logic [CNT_W-1:0] PRELOAD_TOP4 = 3'd1;

	//----------------------------------------
	// Pixel types
	//----------------------------------------
	typedef logic [PIX_W-1:0] pixel_t;

	// p0 is the leftmost or topmost pixel of the group
	typedef struct packed {
		pixel_t p3;
		pixel_t p2;
		pixel_t p1;
		pixel_t p0;
	} pix4_t;

	typedef logic [GRP_W-1:0] grp_t;

	//----------------------------------------
	// Macroblock kind and 16x16 modes
	//----------------------------------------
	typedef enum logic [1:0] {
		MB_INTER   = 2'd0,
		MB_INTRA16 = 2'd1,
		MB_INTRA4  = 2'd2
	} mb_kind_e;

	typedef enum logic [1:0] {
		I16_VERTICAL   = 2'd0,
		I16_HORIZONTAL = 2'd1,
		I16_DC         = 2'd2,
		I16_PLANE      = 2'd3
	} i16_mode_e;

	// Per-cycle state of the decoder's block counters
	typedef struct packed {
		logic [BLK_W-1:0] blk_idx;
		mb_kind_e         mb_kind;
		i16_mode_e        i16_mode;
		logic [CNT_W-1:0] preload_cnt;
		logic [CNT_W-1:0] sum_cnt;
		logic [CNT_W-1:0] calc_cnt;
	} nbr_ctrl_t;

	// Write command, the same for every lane
	typedef struct packed {
		logic left_en;
		grp_t left_grp;
		logic top_en;
		grp_t top_grp;
	} nbr_wr_t;

	// Block index to group, following the 4x4 zigzag scan
	function automatic grp_t row_grp(input logic [BLK_W-1:0] blk);
		return {blk[3], blk[1]};
	endfunction

	function automatic grp_t col_grp(input logic [BLK_W-1:0] blk);
		return {blk[2], blk[0]};
	endfunction

endpackage

//--- src/nbr_load_ctrl.sv
// Neighbour load controller
// Turns block index, mode and counters into left and top write commands
`timescale 1ns/1ps

module nbr_load_ctrl
	import intra_nbr_pkg::*;
(
	input  nbr_ctrl_t ctrl,
	input  logic      left_load,
	input  pix4_t     top_ram_word,
	input  pix4_t     right_column,
	input  pix4_t     bottom_row,
	output nbr_wr_t   wr,
	output pixel_t    left_pix [LANES],
	output pixel_t    top_pix  [LANES]
);

	typedef enum logic [1:0] {
		TOP_NONE = 2'd0,
		TOP_RAM  = 2'd1,
		TOP_SUM  = 2'd2
	} top_src_e;

	top_src_e top_src;
	grp_t     top_grp;
	grp_t     blk_row;
	grp_t     blk_col;
	pix4_t    top_word;

	assign blk_row = row_grp(ctrl.blk_idx);
	assign blk_col = col_grp(ctrl.blk_idx);

	//----------------------------------------
	// Left column capture
	//----------------------------------------
	assign wr.left_en  = left_load;
	assign wr.left_grp = blk_row;

	assign left_pix[0] = right_column.p0;
	assign left_pix[1] = right_column.p1;
	assign left_pix[2] = right_column.p2;
	assign left_pix[3] = right_column.p3;

	//----------------------------------------
	// Top row source decision
	//----------------------------------------
	always_comb
	begin
		top_src = TOP_NONE;
		top_grp = blk_col;
		case (ctrl.mb_kind)
			MB_INTRA4:
			begin
				// Blocks 0, 1, 4 and 5 sit on the macroblock's top edge
				if (ctrl.preload_cnt == PRELOAD_TOP4 && blk_row == 2'd0)
					top_src = TOP_RAM;
				// Bottom row of the last block row has no consumer
				else if (ctrl.sum_cnt == SUM_READY && blk_row != 2'd3)
					top_src = TOP_SUM;
			end
			MB_INTRA16:
			begin
				// Whole top line preloaded, left group first
				case (ctrl.preload_cnt)
					3'd4:
					begin
						top_src = TOP_RAM;
						top_grp = 2'd0;
					end
					3'd3:
					begin
						top_src = TOP_RAM;
						top_grp = 2'd1;
					end
					3'd2:
					begin
						top_src = TOP_RAM;
						top_grp = 2'd2;
					end
					3'd1:
					begin
						top_src = TOP_RAM;
						top_grp = 2'd3;
					end
					default:
						top_src = TOP_NONE;
				endcase
			end
			default:
				top_src = TOP_NONE;
		endcase
	end

	assign wr.top_en  = (top_src != TOP_NONE);
	assign wr.top_grp = top_grp;

	assign top_word = (top_src == TOP_SUM) ? bottom_row : top_ram_word;

	assign top_pix[0] = top_word.p0;
	assign top_pix[1] = top_word.p1;
	assign top_pix[2] = top_word.p2;
	assign top_pix[3] = top_word.p3;

endmodule

//--- src/nbr_lane.sv
// Neighbour pixel lane for one engine position
// Holds pixel i of each left and top group with group-selected reads
`timescale 1ns/1ps

module nbr_lane
	import intra_nbr_pkg::*;
(
	input  logic    gclk_intra_mbAddrD,
	input  logic    reset_n,
	input  nbr_wr_t wr,
	input  pixel_t  left_in,
	input  pixel_t  top_in,
	input  grp_t    a_grp,
	input  grp_t    b_grp,
	output pixel_t  left_out,
	output pixel_t  top_out
);

	pixel_t left_q [GROUPS];
	pixel_t top_q  [GROUPS];

	//----------------------------------------
	// Left pixels
	//----------------------------------------
	always_ff @(posedge gclk_intra_mbAddrD or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int g = 0; g < GROUPS; g++)
				left_q[g] <= '0;
		end
		else if (wr.left_en)
			left_q[wr.left_grp] <= left_in;
	end

	//----------------------------------------
	// Top pixels
	//----------------------------------------
	always_ff @(posedge gclk_intra_mbAddrD or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int g = 0; g < GROUPS; g++)
				top_q[g] <= '0;
		end
		else if (wr.top_en)
			top_q[wr.top_grp] <= top_in;
	end

	// Combinational read-back
	assign left_out = left_q[a_grp];
	assign top_out  = top_q[b_grp];

endmodule

//--- src/nbr_window_out.sv
// Neighbour window unit
// Assembles lane reads into the A and B windows and gates them by mode
`timescale 1ns/1ps

module nbr_window_out
	import intra_nbr_pkg::*;
(
	input  nbr_ctrl_t ctrl,
	input  logic      mbaddr_a_avail,
	input  pixel_t    lane_left [LANES],
	input  pixel_t    lane_top  [LANES],
	output grp_t      a_grp,
	output grp_t      b_grp,
	output pix4_t     window_a,
	output pix4_t     window_b
);

	logic  calc_active;
	logic  a_use;
	logic  b_use;
	pix4_t left_word;
	pix4_t top_word;

	// Left neighbours follow the block row, top neighbours the block column
	assign a_grp = row_grp(ctrl.blk_idx);
	assign b_grp = col_grp(ctrl.blk_idx);

	assign left_word = '{p3: lane_left[3], p2: lane_left[2],
		p1: lane_left[1], p0: lane_left[0]};
	assign top_word  = '{p3: lane_top[3], p2: lane_top[2],
		p1: lane_top[1], p0: lane_top[0]};

	assign calc_active = (ctrl.calc_cnt != '0) && (ctrl.mb_kind != MB_INTER);

	//----------------------------------------
	// Mode gating
	//----------------------------------------
	always_comb
	begin
		a_use = 1'b0;
		b_use = 1'b0;
		if (calc_active)
		begin
			if (ctrl.mb_kind == MB_INTRA4)
			begin
				a_use = 1'b1;
				b_use = 1'b1;
			end
			else
			begin
				case (ctrl.i16_mode)
					I16_VERTICAL:
						b_use = 1'b1;
					I16_HORIZONTAL:
						a_use = 1'b1;
					I16_DC:
					begin
						// DC drops the left term when mbAddrA is missing
						a_use = mbaddr_a_avail;
						b_use = 1'b1;
					end
					I16_PLANE:
					begin
						a_use = 1'b0;
						b_use = 1'b0;
					end
					default:
					begin
						a_use = 1'b0;
						b_use = 1'b0;
					end
				endcase
			end
		end
	end

	assign window_a = a_use ? left_word : '0;
	assign window_b = b_use ? top_word  : '0;

endmodule

//--- src/intra_nbr_regs.sv
// Intra luma neighbour registers, top level
// Load controller, four pixel lanes and the window unit
`timescale 1ns/1ps

module intra_nbr_regs
	import intra_nbr_pkg::*;
(
	input  logic      gclk_intra_mbAddrD,
	input  logic      reset_n,
	input  nbr_ctrl_t ctrl,
	input  logic      left_load,
	input  logic      mbaddr_a_avail,
	input  pix4_t     top_ram_word,
	input  pix4_t     right_column,
	input  pix4_t     bottom_row,
	output pix4_t     window_a,
	output pix4_t     window_b
);

	nbr_wr_t wr;
	pixel_t  left_pix  [LANES];
	pixel_t  top_pix   [LANES];
	pixel_t  lane_left [LANES];
	pixel_t  lane_top  [LANES];
	grp_t    a_grp;
	grp_t    b_grp;

	nbr_load_ctrl u_load (
		.ctrl         (ctrl),
		.left_load    (left_load),
		.top_ram_word (top_ram_word),
		.right_column (right_column),
		.bottom_row   (bottom_row),
		.wr           (wr),
		.left_pix     (left_pix),
		.top_pix      (top_pix)
	);

	// One lane per prediction engine
	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		nbr_lane u_lane (
			.gclk_intra_mbAddrD (gclk_intra_mbAddrD),
			.reset_n            (reset_n),
			.wr                 (wr),
			.left_in            (left_pix[i]),
			.top_in             (top_pix[i]),
			.a_grp              (a_grp),
			.b_grp              (b_grp),
			.left_out           (lane_left[i]),
			.top_out            (lane_top[i])
		);
	end

	nbr_window_out u_win (
		.ctrl           (ctrl),
		.mbaddr_a_avail (mbaddr_a_avail),
		.lane_left      (lane_left),
		.lane_top       (lane_top),
		.a_grp          (a_grp),
		.b_grp          (b_grp),
		.window_a       (window_a),
		.window_b       (window_b)
	);

endmodule

//--- dv/intra_nbr_chk.sv
// Neighbour register checker
// Gating properties on the windows of the top level
`timescale 1ns/1ps

module intra_nbr_chk
	import intra_nbr_pkg::*;
(
	input logic      gclk_intra_mbAddrD,
	input logic      reset_n,
	input nbr_ctrl_t ctrl,
	input logic      mbaddr_a_avail,
	input pix4_t     window_a,
	input pix4_t     window_b
);

	// No calculation step, no neighbours
	a_idle_zero: assert property (@(posedge gclk_intra_mbAddrD) disable iff (!reset_n)
		(ctrl.calc_cnt == 3'd0) |-> ((window_a == '0) && (window_b == '0)))
	else
		$error("windows not zero while calc_cnt is zero");

	a_inter_zero: assert property (@(posedge gclk_intra_mbAddrD) disable iff (!reset_n)
		(ctrl.mb_kind == MB_INTER) |-> ((window_a == '0) && (window_b == '0)))
	else
		$error("windows not zero for an inter macroblock");

	// DC loses its left term without mbAddrA
	a_dc_no_left: assert property (@(posedge gclk_intra_mbAddrD) disable iff (!reset_n)
		((ctrl.mb_kind == MB_INTRA16) && (ctrl.i16_mode == I16_DC) && !mbaddr_a_avail)
		|-> (window_a == '0))
	else
		$error("window_a not zero for DC without mbAddrA");

endmodule

bind intra_nbr_regs intra_nbr_chk u_chk (
	.gclk_intra_mbAddrD (gclk_intra_mbAddrD),
	.reset_n            (reset_n),
	.ctrl               (ctrl),
	.mbaddr_a_avail     (mbaddr_a_avail),
	.window_a           (window_a),
	.window_b           (window_b)
);

//--- dv/tb_intra_nbr.sv
// Testbench for the intra luma neighbour registers
// LFSR stimulus checked against a reference model of the write and gating rules
`timescale 1ns/1ps

module tb_intra_nbr
	import intra_nbr_pkg::*;
();

	localparam int RESET_CYCLES    = 3;
	localparam int DIRECTED_CYCLES = 100;
	localparam int RANDOM_CYCLES   = 400;
	localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50;

	typedef struct packed {
		pix4_t a;
		pix4_t b;
	} win_pair_t;

	logic        gclk_intra_mbAddrD;
	logic        reset_n;
	nbr_ctrl_t   ctrl;
	logic        left_load;
	logic        mbaddr_a_avail;
	pix4_t       top_ram_word;
	pix4_t       right_column;
	pix4_t       bottom_row;
	pix4_t       window_a;
	pix4_t       window_b;
	logic [31:0] lfsr_state;
	int          cycle_count;
	win_pair_t   expected;
	// Reference copy of the 16 left and 16 top pixels
	pix4_t       left_m [GROUPS];
	pix4_t       top_m  [GROUPS];

	intra_nbr_regs dut0 (
		.gclk_intra_mbAddrD (gclk_intra_mbAddrD),
		.reset_n            (reset_n),
		.ctrl               (ctrl),
		.left_load          (left_load),
		.mbaddr_a_avail     (mbaddr_a_avail),
		.top_ram_word       (top_ram_word),
		.right_column       (right_column),
		.bottom_row         (bottom_row),
		.window_a           (window_a),
		.window_b           (window_b)
	);

	always #4 gclk_intra_mbAddrD = ~gclk_intra_mbAddrD;

	//----------------------------------------
	// Random source and helpers
	//----------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	// Zigzag block index from row and column group
	function automatic logic [3:0] blk_of(input int row, input int col);
		return {row[1], col[1], row[0], col[0]};
	endfunction

	//----------------------------------------
	// Reference model
	//----------------------------------------
	function automatic win_pair_t predict_windows(input nbr_ctrl_t c, input logic avail);
		win_pair_t  w;
		logic [1:0] row;
		logic [1:0] col;
		logic       use_a;
		logic       use_b;
		row   = {c.blk_idx[3], c.blk_idx[1]};
		col   = {c.blk_idx[2], c.blk_idx[0]};
		use_a = 1'b0;
		use_b = 1'b0;
		if (c.calc_cnt != 3'd0 && c.mb_kind == MB_INTRA4)
		begin
			use_a = 1'b1;
			use_b = 1'b1;
		end
		else if (c.calc_cnt != 3'd0 && c.mb_kind == MB_INTRA16)
		begin
			use_a = (c.i16_mode == I16_HORIZONTAL) || (c.i16_mode == I16_DC && avail);
			use_b = (c.i16_mode == I16_VERTICAL) || (c.i16_mode == I16_DC);
		end
		w.a = use_a ? left_m[row] : '0;
		w.b = use_b ? top_m[col] : '0;
		return w;
	endfunction

	always @(posedge gclk_intra_mbAddrD or negedge reset_n)
	begin : model_update
		logic [1:0] row;
		logic [1:0] col;
		logic [2:0] pre_grp;
		if (!reset_n)
		begin
			for (int g = 0; g < GROUPS; g++)
			begin
				left_m[g] = '0;
				top_m[g]  = '0;
			end
		end
		else
		begin
			row     = {ctrl.blk_idx[3], ctrl.blk_idx[1]};
			col     = {ctrl.blk_idx[2], ctrl.blk_idx[0]};
			pre_grp = 3'd4 - ctrl.preload_cnt;
			if (left_load)
				left_m[row] = right_column;
			if (ctrl.mb_kind == MB_INTRA4)
			begin
				if (ctrl.preload_cnt == PRELOAD_TOP4 && ctrl.blk_idx inside {4'd0, 4'd1, 4'd4, 4'd5})
					top_m[col] = top_ram_word;
				else if (ctrl.sum_cnt == SUM_READY && row != 2'd3)
					top_m[col] = bottom_row;
			end
			else if (ctrl.mb_kind == MB_INTRA16 && ctrl.preload_cnt inside {[3'd1:3'd4]})
				top_m[pre_grp[1:0]] = top_ram_word;
		end
	end

	//----------------------------------------
	// Compare and timeout
	//----------------------------------------
	task automatic check_window_a(input pix4_t got, input pix4_t exp);
		if (got !== exp)
		begin
			$display("error at time %0t: window_a is %h, expected %h for blk_idx %0d",
				$time, got, exp, ctrl.blk_idx);
			$display("=== FAIL ===");
			$fatal(1, "window_a mismatch");
		end
	endtask

	task automatic check_window_b(input pix4_t got, input pix4_t exp);
		if (got !== exp)
		begin
			$display("error at time %0t: window_b is %h, expected %h for blk_idx %0d",
				$time, got, exp, ctrl.blk_idx);
			$display("=== FAIL ===");
			$fatal(1, "window_b mismatch");
		end
	endtask

	always @(negedge gclk_intra_mbAddrD)
	begin
		if (reset_n)
		begin
			expected = predict_windows(ctrl, mbaddr_a_avail);
			check_window_a(window_a, expected.a);
			check_window_b(window_b, expected.b);
		end
	end

	always @(posedge gclk_intra_mbAddrD)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	//----------------------------------------
	// Stimulus
	//----------------------------------------
	task automatic drive(input logic [3:0] blk, input mb_kind_e kind, input i16_mode_e mode,
		input logic [2:0] pre, input logic [2:0] sum, input logic [2:0] calc,
		input logic ld, input logic avail);
		@(posedge gclk_intra_mbAddrD);
		#1;
		ctrl = '{blk_idx: blk, mb_kind: kind, i16_mode: mode, preload_cnt: pre,
			sum_cnt: sum, calc_cnt: calc};
		left_load      = ld;
		mbaddr_a_avail = avail;
		top_ram_word   = take_bits(32);
		right_column   = take_bits(32);
		bottom_row     = take_bits(32);
	endtask

	initial
	begin : stimulus
		logic [31:0] r;
		mb_kind_e    kind;
		gclk_intra_mbAddrD = 1'b0;
		reset_n            = 1'b0;
		ctrl               = '0;
		left_load          = 1'b0;
		mbaddr_a_avail     = 1'b0;
		top_ram_word       = '0;
		right_column       = '0;
		bottom_row         = '0;
		lfsr_state         = 32'hea81;
		cycle_count        = 0;
		repeat (RESET_CYCLES) @(posedge gclk_intra_mbAddrD);
		#1;
		reset_n = 1'b1;

		// Nothing stored yet
		for (int i = 0; i < 16; i++)
			drive(i[3:0], MB_INTRA4, I16_VERTICAL, 3'd0, 3'd0, 3'd1, 1'b0, 1'b1);

		// Left capture per row group, read back by all four blocks of the row
		for (int g = 0; g < GROUPS; g++)
		begin
			drive(blk_of(g, 0), MB_INTRA4, I16_VERTICAL, 3'd0, 3'd0, 3'd0, 1'b1, 1'b1);
			for (int c = 0; c < GROUPS; c++)
				drive(blk_of(g, c), MB_INTRA4, I16_VERTICAL, 3'd0, 3'd0, 3'd1, 1'b0, 1'b1);
		end

		// Intra4x4 top line: RAM preload, then bottom rows while other blocks read
		for (int c = 0; c < GROUPS; c++)
			drive(blk_of(0, c), MB_INTRA4, I16_VERTICAL, PRELOAD_TOP4, 3'd0, 3'd1, 1'b0, 1'b1);
		for (int c = 0; c < GROUPS; c++)
			drive(blk_of(2, c), MB_INTRA4, I16_VERTICAL, 3'd0, 3'd0, 3'd1, 1'b0, 1'b1);
		for (int i = 0; i < 16; i++)
			drive(i[3:0], MB_INTRA4, I16_VERTICAL, 3'd0, SUM_READY, 3'd2, 1'b0, 1'b1);
		for (int c = 0; c < GROUPS; c++)
			drive(blk_of(3, c), MB_INTRA4, I16_VERTICAL, 3'd0, 3'd0, 3'd1, 1'b0, 1'b1);

		// Intra16x16 preload order, then every mode on the diagonal blocks
		for (int k = 4; k > 0; k--)
			drive(4'd0, MB_INTRA16, I16_VERTICAL, k[2:0], 3'd0, 3'd0, 1'b0, 1'b1);
		for (int m = 0; m < 4; m++)
			for (int g = 0; g < GROUPS; g++)
				drive(blk_of(g, g), MB_INTRA16, i16_mode_e'(m[1:0]), 3'd0, 3'd0, 3'd1, 1'b0, 1'b1);

		// DC without mbAddrA, then inter counters that must not write
		for (int g = 0; g < GROUPS; g++)
			drive(blk_of(g, g), MB_INTRA16, I16_DC, 3'd0, 3'd0, 3'd1, 1'b0, 1'b0);
		for (int k = 0; k < 8; k++)
			drive(blk_of(k % 4, 3 - k % 4), MB_INTER, i16_mode_e'(k[1:0]), k[2:0], SUM_READY,
				3'd1, 1'b0, 1'b1);
		for (int g = 0; g < GROUPS; g++)
			drive(blk_of(g, g), MB_INTRA4, I16_VERTICAL, 3'd0, 3'd0, 3'd1, 1'b0, 1'b1);

		for (int n = 0; n < RANDOM_CYCLES; n++)
		begin
			r    = take_bits(19);
			kind = (r[1:0] == 2'd3) ? MB_INTRA4 : mb_kind_e'(r[1:0]);
			drive(r[7:4], kind, i16_mode_e'(r[3:2]), r[10:8], r[13:11], r[16:14], r[17], r[18]);
		end

		// Past the last compare
		@(posedge gclk_intra_mbAddrD);
		#1;
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- project.f
src/intra_nbr_pkg.sv
src/nbr_load_ctrl.sv
src/nbr_lane.sv
src/nbr_window_out.sv
src/intra_nbr_regs.sv
dv/intra_nbr_chk.sv
dv/tb_intra_nbr.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the intra neighbour testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_intra_nbr

verilator --binary --timing --assert -f project.f --top-module tb_intra_nbr -o "$BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	echo "result: passed"
	exit 0
fi

echo "result: failed"
exit 1
